// File: run_sim.sh
#!/bin/sh
# Build and run the execution cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_cluster_tb \
    -f tb.f --Mdir obj_dir -o exec_cluster_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/exec_cluster_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: source/cdb_broadcast.sv
// CDB broadcaster
// Rotating-priority pick of up to CDB_NUM lane results per cycle,
// packed from slot 0 into registered CDB and register file writes

`default_nettype none

`include "cdb_consts.svh"

module cdb_broadcast
    import core_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire fu_bc_t [`FU_NUM-1:0] fu_bc_i,
    output bc_fu_t [`FU_NUM-1:0]    bc_fu_o,
    output cdb_t   [`CDB_NUM-1:0]   cdb_o,
    output bc_prf_t [`CDB_NUM-1:0]  bc_prf_o
);

    // Scan start, steps every cycle
    fu_idx_t                    ptr_q;
    // Combinational pick
    logic [`FU_NUM-1:0]         grant;
    cdb_t   [`CDB_NUM-1:0]      cdb_d;
    bc_prf_t [`CDB_NUM-1:0]     prf_d;
    // Output registers
    cdb_t   [`CDB_NUM-1:0]      cdb_q;
    bc_prf_t [`CDB_NUM-1:0]     prf_q;

    // ==================================================
    // Rotating pointer
    // ==================================================

    // Wraps through the lanes on its own width
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= ptr_q + fu_idx_t'(1);
        end
    end

    // ==================================================
    // Selection
    // ==================================================

    always_comb begin
        fu_idx_t                    idx;
        logic [$clog2(`CDB_NUM)-1:0] slot;
        logic                       full;
        grant = '0;
        cdb_d = '0;
        prf_d = '0;
        slot  = '0;
        full  = 1'b0;
        idx   = ptr_q;
        for (int k = 0; k < `FU_NUM; k++) begin
            idx = ptr_q + fu_idx_t'(k);
            if (fu_bc_i[idx].valid && !full) begin
                grant[idx] = 1'b1;
                // CDB record
                cdb_d[slot].valid      = 1'b1;
                cdb_d[slot].pc         = fu_bc_i[idx].pc;
                cdb_d[slot].tag        = fu_bc_i[idx].tag;
                cdb_d[slot].rob_idx    = fu_bc_i[idx].rob_idx;
                cdb_d[slot].thread_idx = fu_bc_i[idx].thread_idx;
                cdb_d[slot].br_result  = fu_bc_i[idx].br_result;
                cdb_d[slot].br_target  = fu_bc_i[idx].br_target;
                // Matching register write
                prf_d[slot].wr_en      = 1'b1;
                prf_d[slot].wr_addr    = fu_bc_i[idx].tag;
                prf_d[slot].data_in    = fu_bc_i[idx].rd_value;
                // Next free slot, stop once all are taken
                if (slot == `CDB_NUM - 1) begin
                    full = 1'b1;
                end else begin
                    slot = slot + 1'b1;
                end
            end
        end
    end

    // Grant lines back to the lanes
    always_comb begin
        for (int i = 0; i < `FU_NUM; i++) begin
            bc_fu_o[i].ready = grant[i];
        end
    end

    // Records leave one edge after the grant cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cdb_q <= '0;
            prf_q <= '0;
        end else begin
            cdb_q <= cdb_d;
            prf_q <= prf_d;
        end
    end

    assign cdb_o    = cdb_q;
    assign bc_prf_o = prf_q;

endmodule

`default_nettype wire

// File: source/cdb_consts.svh
// Execution cluster constants
// Lane count, CDB slot count, register file size and field widths
// shared by the packages and the RTL

`ifndef CDB_CONSTS_SVH
`define CDB_CONSTS_SVH

// Functional-unit lanes
`define FU_NUM      4
// Lane index width, log2 of FU_NUM
`define FU_IDX_W    2

// Broadcast slots per cycle
`define CDB_NUM     2

// Physical register file depth, addressed by tag
`define PREG_NUM    16
`define TAG_W       4

// Reorder buffer and thread fields, carried only
`define ROB_W       5
`define THR_W       1

// Data path width
`define XLEN        32

`endif

// File: source/core_types_pkg.sv
// Core scalar types
// Widths with a meaning of their own plus the ALU opcode encoding

`default_nettype none

package core_types_pkg;

`include "cdb_consts.svh"

    // Physical register tag, also the register file address
    typedef logic [`TAG_W-1:0]      tag_t;

    // ROB slot, only carried through
    typedef logic [`ROB_W-1:0]      rob_idx_t;

    // Hardware thread id
    typedef logic [`THR_W-1:0]      thread_idx_t;

    // Data and PC words
    typedef logic [`XLEN-1:0]       word_t;

    // Lane select
    typedef logic [`FU_IDX_W-1:0]   fu_idx_t;

    // ALU operations of a lane
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2
    } alu_op_e;

endpackage

`default_nettype wire

// File: source/exec_cluster_top.sv
// Execution cluster top
// Dispatcher, FU_NUM lanes, CDB broadcaster and register file

`default_nettype none

`include "cdb_consts.svh"

module exec_cluster_top
    import core_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire logic                   issue_valid_i,
    input  wire issue_t                 issue_i,
    input  wire fu_idx_t                fu_sel_i,
    output logic                        issue_reject_o,
    output logic [`FU_NUM-1:0]          lane_busy_o,
    output cdb_t [`CDB_NUM-1:0]         cdb_o,
    input  wire tag_t                   rd_addr_i,
    output word_t                       rd_data_o
);

    // Dispatcher to lanes
    logic [`FU_NUM-1:0]         lane_start;
    issue_t                     lane_op;
    // Lane handshake with the broadcaster
    fu_bc_t [`FU_NUM-1:0]       fu_bc;
    bc_fu_t [`FU_NUM-1:0]       bc_fu;
    // Register file writes
    bc_prf_t [`CDB_NUM-1:0]     bc_prf;

    fu_dispatch u_dispatch (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .fu_sel_i       (fu_sel_i),
        .lane_busy_i    (lane_busy_o),
        .lane_start_o   (lane_start),
        .lane_op_o      (lane_op),
        .issue_reject_o (issue_reject_o)
    );

    // One lane per functional unit
    for (genvar i = 0; i < `FU_NUM; i++) begin : lane
        fu_lane u_lane (
            .clk_i    (clk_i),
            .rst_i    (rst_i),
            .start_i  (lane_start[i]),
            .op_i     (lane_op),
            .bc_i     (bc_fu[i]),
            .result_o (fu_bc[i]),
            .busy_o   (lane_busy_o[i])
        );
    end

    cdb_broadcast u_broadcast (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .fu_bc_i  (fu_bc),
        .bc_fu_o  (bc_fu),
        .cdb_o    (cdb_o),
        .bc_prf_o (bc_prf)
    );

    phys_reg_file u_prf (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_i      (bc_prf),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

endmodule

`default_nettype wire

// File: source/fu_dispatch.sv
// Issue dispatcher
// Steers an issued operation to the selected lane; an issue to a
// busy lane is dropped and flagged with a one-cycle reject

`default_nettype none

`include "cdb_consts.svh"

module fu_dispatch
    import core_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire logic                   issue_valid_i,
    input  wire issue_t                 issue_i,
    input  wire fu_idx_t                fu_sel_i,
    input  wire logic [`FU_NUM-1:0]     lane_busy_i,
    output logic [`FU_NUM-1:0]          lane_start_o,
    output issue_t                      lane_op_o,
    output logic                        issue_reject_o
);

    // Selected lane already holds an operation
    logic sel_busy;

    assign sel_busy = lane_busy_i[fu_sel_i];

    // ==================================================
    // Start decode
    // ==================================================

    // One-hot start, only to an idle lane
    always_comb begin
        lane_start_o = '0;
        if (issue_valid_i && !sel_busy) begin
            lane_start_o[fu_sel_i] = 1'b1;
        end
    end

    // Operation goes to every lane, start picks the taker
    assign lane_op_o = issue_i;

    // ==================================================
    // Reject pulse
    // ==================================================

    // High for the cycle after a refused issue
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            issue_reject_o <= 1'b0;
        end else begin
            issue_reject_o <= issue_valid_i && sel_busy;
        end
    end

endmodule

`default_nettype wire

// File: source/fu_lane.sv
// Functional-unit lane
// Latches one operation, computes add/sub/xor over two stages and
// holds the result record until the broadcaster grants it

`default_nettype none

module fu_lane
    import core_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       start_i,
    input  wire issue_t     op_i,
    input  wire bc_fu_t     bc_i,
    output fu_bc_t          result_o,
    output logic            busy_o
);

    // Latched operation held while busy
    issue_t op_q;
    // Stage valids
    logic   s0_vld_q;
    logic   s1_vld_q;
    logic   out_vld_q;
    // ALU result and its stage register
    word_t  alu_res;
    word_t  res_q;
    logic   busy_q;

    // ==================================================
    // ALU
    // ==================================================

    always_comb begin
        case (op_q.opcode)
            OP_ADD:  alu_res = op_q.op_a + op_q.op_b;
            OP_SUB:  alu_res = op_q.op_a - op_q.op_b;
            OP_XOR:  alu_res = op_q.op_a ^ op_q.op_b;
            default: alu_res = '0;
        endcase
    end

    // Operand latch and first-stage result
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            op_q <= op_i;
        end
        if (s0_vld_q) begin
            res_q <= alu_res;
        end
    end

    // ==================================================
    // Pipeline control
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s0_vld_q  <= 1'b0;
            s1_vld_q  <= 1'b0;
            out_vld_q <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            s0_vld_q <= start_i;
            s1_vld_q <= s0_vld_q;
            // Second stage raises valid, grant drops it
            if (s1_vld_q) begin
                out_vld_q <= 1'b1;
            end else if (out_vld_q && bc_i.ready) begin
                out_vld_q <= 1'b0;
            end
            // Busy from accept until the granted edge
            if (start_i) begin
                busy_q <= 1'b1;
            end else if (out_vld_q && bc_i.ready) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Held record; branch outcome is never taken here
    always_comb begin
        result_o.valid      = out_vld_q;
        result_o.pc         = op_q.pc;
        result_o.tag        = op_q.tag;
        result_o.rob_idx    = op_q.rob_idx;
        result_o.thread_idx = op_q.thread_idx;
        result_o.rd_value   = res_q;
        result_o.br_result  = 1'b0;
        result_o.br_target  = op_q.pc;
    end

    assign busy_o = busy_q;

endmodule

`default_nettype wire

// File: source/phys_reg_file.sv
// Physical register file
// CDB_NUM write ports taken in slot order, one combinational read
// port; cleared to zero on reset

`default_nettype none

`include "cdb_consts.svh"

module phys_reg_file
    import core_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire bc_prf_t [`CDB_NUM-1:0]     wr_i,
    input  wire tag_t                       rd_addr_i,
    output word_t                           rd_data_o
);

    // Storage, one word per tag
    word_t regs [`PREG_NUM];

    // ==================================================
    // Write ports
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int r = 0; r < `PREG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Higher slot wins on a shared address
            for (int s = 0; s < `CDB_NUM; s++) begin
                if (wr_i[s].wr_en) begin
                    regs[wr_i[s].wr_addr] <= wr_i[s].data_in;
                end
            end
        end
    end

    // ==================================================
    // Read port
    // ==================================================

    // No bypass, a write shows after its edge
    assign rd_data_o = regs[rd_addr_i];

endmodule

`default_nettype wire

// File: source/wb_bus_pkg.sv
// Write-back bus records
// Issue, lane result, grant, register file write and CDB slot formats

`default_nettype none

package wb_bus_pkg;

    import core_types_pkg::*;

    // ==================================================
    // Issue side
    // ==================================================

    // One operation from the issue stage
    typedef struct packed {
        alu_op_e        opcode;
        word_t          op_a;
        word_t          op_b;
        word_t          pc;
        tag_t           tag;
        rob_idx_t       rob_idx;
        thread_idx_t    thread_idx;
    } issue_t;

    // ==================================================
    // Lane and broadcaster handshake
    // ==================================================

    // Result held by a lane until granted
    typedef struct packed {
        logic           valid;
        word_t          pc;
        tag_t           tag;
        rob_idx_t       rob_idx;
        thread_idx_t    thread_idx;
        word_t          rd_value;
        logic           br_result;
        word_t          br_target;
    } fu_bc_t;

    // Grant back to a lane
    typedef struct packed {
        logic           ready;
    } bc_fu_t;

    // ==================================================
    // Broadcast outputs
    // ==================================================

    // One register file write port
    typedef struct packed {
        logic           wr_en;
        tag_t           wr_addr;
        word_t          data_in;
    } bc_prf_t;

    // One CDB slot, no data word on the bus itself
    typedef struct packed {
        logic           valid;
        word_t          pc;
        tag_t           tag;
        rob_idx_t       rob_idx;
        thread_idx_t    thread_idx;
        logic           br_result;
        word_t          br_target;
    } cdb_t;

endpackage

`default_nettype wire

// File: tb.f
+incdir+source
source/core_types_pkg.sv
source/wb_bus_pkg.sv
source/fu_dispatch.sv
source/fu_lane.sv
source/cdb_broadcast.sv
source/phys_reg_file.sv
source/exec_cluster_top.sv
verification/exec_cluster_properties.sv
verification/exec_cluster_tb.sv

// File: verification/exec_cluster_properties.sv
// CDB broadcaster checks
// Bound assertions on slot packing, grant legality and reset state

`default_nettype none

`include "cdb_consts.svh"

module exec_cluster_properties
    import core_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire fu_bc_t [`FU_NUM-1:0]       fu_bc_i,
    input  wire logic [`FU_NUM-1:0]         grant_i,
    input  wire cdb_t [`CDB_NUM-1:0]        cdb_i,
    input  wire bc_prf_t [`CDB_NUM-1:0]     prf_i
);

    // Flattened valid bits
    logic [`FU_NUM-1:0]     lane_vld;
    logic [`CDB_NUM-1:0]    slot_vld;
    logic [`CDB_NUM-1:0]    wr_vld;

    always_comb begin
        for (int i = 0; i < `FU_NUM; i++) begin
            lane_vld[i] = fu_bc_i[i].valid;
        end
        for (int s = 0; s < `CDB_NUM; s++) begin
            slot_vld[s] = cdb_i[s].valid;
            wr_vld[s]   = prf_i[s].wr_en;
        end
    end

    // ==================================================
    // Grant and slot rules
    // ==================================================

    // Valid slots form a run starting at slot 0
    slot_packing: assert property (@(posedge clk_i) disable iff (rst_i)
        (slot_vld & (slot_vld + 1'b1)) == '0)
        else $error("CDB slots are not packed from slot 0");

    // Only lanes holding a result get a grant
    grant_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        (grant_i & ~lane_vld) == '0)
        else $error("lane granted without a valid result");

    grant_limit: assert property (@(posedge clk_i) disable iff (rst_i)
        $countones(grant_i) <= `CDB_NUM)
        else $error("more grants than CDB slots in one cycle");

    // Registered outputs cleared by the reset edge
    reset_clears: assert property (@(posedge clk_i)
        rst_i |=> (slot_vld == '0 && wr_vld == '0))
        else $error("CDB or write enable high after a reset edge");

endmodule

bind cdb_broadcast exec_cluster_properties u_props (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .fu_bc_i (fu_bc_i),
    .grant_i (grant),
    .cdb_i   (cdb_o),
    .prf_i   (bc_prf_o)
);

`default_nettype wire

// File: verification/exec_cluster_tb.sv
// Execution cluster testbench
// Table-driven issue into the lanes, CDB scoreboard by tag,
// reject checks and register file read-back

`default_nettype none

`include "cdb_consts.svh"

module exec_cluster_tb
    import core_types_pkg::*;
    import wb_bus_pkg::*;
();

    // One row of the issue table
    typedef struct packed {
        logic       wait_idle;
        fu_idx_t    lane;
        alu_op_e    op;
        tag_t       tag;
        logic       reject;
    } stim_t;

    localparam int NUM_ROWS   = 11;
    localparam int TIMEOUT    = 40;
    localparam int CLK_PERIOD = 8;

    logic                   clk_i;
    logic                   rst_i;
    logic                   issue_valid_i;
    issue_t                 issue_i;
    fu_idx_t                fu_sel_i;
    logic                   issue_reject_o;
    logic [`FU_NUM-1:0]     lane_busy_o;
    cdb_t [`CDB_NUM-1:0]    cdb_o;
    tag_t                   rd_addr_i;
    word_t                  rd_data_o;

    // Columns are idle wait, lane, opcode, tag and reject expected
    stim_t stim_tab [NUM_ROWS] = '{
        '{1'b1, 2'd0, OP_ADD, 4'd1,  1'b0},
        '{1'b1, 2'd1, OP_SUB, 4'd2,  1'b0},
        '{1'b1, 2'd2, OP_XOR, 4'd3,  1'b0},
        '{1'b1, 2'd0, OP_ADD, 4'd4,  1'b0},
        '{1'b0, 2'd1, OP_SUB, 4'd5,  1'b0},
        '{1'b0, 2'd2, OP_XOR, 4'd6,  1'b0},
        '{1'b0, 2'd3, OP_ADD, 4'd7,  1'b0},
        '{1'b1, 2'd0, OP_SUB, 4'd8,  1'b0},
        '{1'b0, 2'd0, OP_XOR, 4'd9,  1'b1},
        '{1'b0, 2'd3, OP_XOR, 4'd10, 1'b0},
        '{1'b1, 2'd2, OP_ADD, 4'd11, 1'b0}
    };

    // Scoreboard indexed by tag
    word_t          exp_val    [`PREG_NUM];
    rob_idx_t       exp_rob    [`PREG_NUM];
    thread_idx_t    exp_thr    [`PREG_NUM];
    word_t          exp_pc     [`PREG_NUM];
    time            issue_time [`PREG_NUM];
    logic           issued     [`PREG_NUM];
    logic           seen       [`PREG_NUM];
    // Reject expected for the row on the bus, and its delayed copy
    logic       rej_exp_drv;
    logic       rej_model;
    int         mismatch_cnt;
    int         fail_cnt;
    int         reject_cnt;
    int         exp_rejects;
    integer     seed;

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    exec_cluster_top dut0 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .fu_sel_i       (fu_sel_i),
        .issue_reject_o (issue_reject_o),
        .lane_busy_o    (lane_busy_o),
        .cdb_o          (cdb_o),
        .rd_addr_i      (rd_addr_i),
        .rd_data_o      (rd_data_o)
    );

    // ==================================================
    // Reference and reporting
    // ==================================================

    // Opcode rule for the expected result
    function automatic word_t alu_expect(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        fail_cnt++;
        $display("%s", what);
    endtask

    // ==================================================
    // Stimulus and waits
    // ==================================================

    // Drives one table row for a single cycle
    task automatic issue_row(input int r);
        issue_t op;
        stim_t  row;
        row           = stim_tab[r];
        op.opcode     = row.op;
        op.op_a       = $random(seed);
        op.op_b       = $random(seed);
        op.pc         = 32'h0000_1000 + word_t'(r * 4);
        op.tag        = row.tag;
        op.rob_idx    = rob_idx_t'(r + 3);
        op.thread_idx = thread_idx_t'(r % 2);
        @(posedge clk_i);
        issue_valid_i <= 1'b1;
        issue_i       <= op;
        fu_sel_i      <= row.lane;
        rej_exp_drv   <= row.reject;
        if (!row.reject) begin
            issued[row.tag]     = 1'b1;
            exp_val[row.tag]    = alu_expect(row.op, op.op_a, op.op_b);
            exp_rob[row.tag]    = op.rob_idx;
            exp_thr[row.tag]    = op.thread_idx;
            exp_pc[row.tag]     = op.pc;
            // DUT takes it at the next edge
            issue_time[row.tag] = $time + CLK_PERIOD;
        end
    endtask

    // Drops the strobe, then waits for every lane to free up
    task automatic wait_lanes_idle();
        int n;
        n = 0;
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        rej_exp_drv   <= 1'b0;
        @(negedge clk_i);
        while (lane_busy_o != '0 && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (lane_busy_o != '0) begin
            report_failure("timeout: lanes still busy");
        end
    endtask

    function automatic int open_results();
        int cnt;
        cnt = 0;
        for (int t = 0; t < `PREG_NUM; t++) begin
            if (issued[t] && !seen[t]) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    task automatic wait_results();
        int n;
        n = 0;
        @(posedge clk_i);
        while (open_results() != 0 && n < TIMEOUT) begin
            @(posedge clk_i);
            n++;
        end
        if (open_results() != 0) begin
            report_failure($sformatf("timeout: %0d results never reached the CDB",
                open_results()));
        end
    endtask

    task automatic read_back_all();
        for (int r = 0; r < `PREG_NUM; r++) begin
            @(posedge clk_i);
            rd_addr_i <= tag_t'(r);
            @(negedge clk_i);
            check_value($sformatf("read tag %0d", r), exp_val[r], rd_data_o);
        end
    endtask

    // ==================================================
    // Monitors
    // ==================================================

    // Reject shows the cycle after the refused issue
    always @(posedge clk_i) begin
        if (rst_i) begin
            rej_model <= 1'b0;
        end else begin
            rej_model <= issue_valid_i && rej_exp_drv;
        end
    end

    // CDB and reject sampled mid-cycle
    always @(negedge clk_i) begin
        tag_t t;
        if (!rst_i) begin
            for (int s = 0; s < `CDB_NUM; s++) begin
                if (cdb_o[s].valid === 1'b1) begin
                    t = cdb_o[s].tag;
                    if (!issued[t] || seen[t]) begin
                        report_failure($sformatf("tag %0d on the CDB was not expected", t));
                    end else begin
                        seen[t] = 1'b1;
                        check_value($sformatf("tag %0d rob_idx", t),
                            word_t'(exp_rob[t]), word_t'(cdb_o[s].rob_idx));
                        check_value($sformatf("tag %0d thread_idx", t),
                            word_t'(exp_thr[t]), word_t'(cdb_o[s].thread_idx));
                        check_value($sformatf("tag %0d pc", t), exp_pc[t], cdb_o[s].pc);
                        check_value($sformatf("tag %0d br_target", t),
                            exp_pc[t], cdb_o[s].br_target);
                        check_value($sformatf("tag %0d br_result", t),
                            '0, word_t'(cdb_o[s].br_result));
                        if ($time < issue_time[t] + 3 * CLK_PERIOD) begin
                            report_failure($sformatf("tag %0d reached the CDB too early", t));
                        end
                    end
                end
            end
            check_value("issue reject", word_t'(rej_model), word_t'(issue_reject_o));
            if (issue_reject_o === 1'b1) begin
                reject_cnt++;
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        seed          = 46289;
        mismatch_cnt  = 0;
        fail_cnt      = 0;
        reject_cnt    = 0;
        exp_rejects   = 0;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        fu_sel_i      = '0;
        rd_addr_i     = '0;
        rej_exp_drv   = 1'b0;
        for (int t = 0; t < `PREG_NUM; t++) begin
            exp_val[t]    = '0;
            exp_rob[t]    = '0;
            exp_thr[t]    = '0;
            exp_pc[t]     = '0;
            issue_time[t] = 0;
            issued[t]     = 1'b0;
            seen[t]       = 1'b0;
        end
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;

        // Cleared register file
        read_back_all();

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (stim_tab[r].wait_idle) begin
                wait_lanes_idle();
            end
            if (stim_tab[r].reject) begin
                exp_rejects++;
            end
            issue_row(r);
        end
        wait_lanes_idle();
        wait_results();

        // Written results with untouched tags still zero
        read_back_all();
        check_value("issue reject count", word_t'(exp_rejects), word_t'(reject_cnt));

        $display("errors: %0d value mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
